/* source/apb_pkg.sv */
// APB bus widths and the transfer sequencer state encoding
package apb_pkg;

  // Address and data widths shared by both sides of the bus
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;

  // One strobe bit per data byte
  localparam int unsigned strb_w = data_w / 8;

  // Sequencer states for one transfer
  //   IDLE     waiting for an upstream setup cycle
  //   SETUP    downstream setup phase, psel high and penable low
  //   ACCESS   downstream access phase, held until the target is ready
  //   RESPOND  upstream response cycle, pready high
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    SETUP   = 2'd1,
    ACCESS  = 2'd2,
    RESPOND = 2'd3
  } apb_state_e;

endpackage

/* source/soc_bus_pkg.sv */
// SoC address map constants, target counts and target index functions
package automatic soc_bus_pkg;

  // Cluster windows, one per stride, each only partly populated
  localparam logic [31:0] cluster_base   = 32'h1000_0000;
  localparam logic [31:0] cluster_stride = 32'h0040_0000;
  localparam logic [31:0] cluster_size   = 32'h0030_0000;

  // First L2 memory port
  localparam logic [31:0] l2_base = 32'h1C00_0000;

  // Peripheral window that goes to the external port
  localparam logic [31:0] ext_win_base = 32'h1A00_0000;
  localparam logic [31:0] ext_win_end  = 32'h1AFF_FFFF;

  // Clusters, then L2 ports, then the single external port
  function int unsigned n_targets(input int unsigned n_clusters, l2_n_ports);
    return n_clusters + l2_n_ports + 1;
  endfunction

  function int unsigned idx_l2(input int unsigned n_clusters);
    return n_clusters;
  endfunction

  function int unsigned idx_ext(input int unsigned n_clusters, l2_n_ports);
    return idx_l2(n_clusters) + l2_n_ports;
  endfunction

  // Never narrower than one bit
  function int unsigned tgt_idx_w(input int unsigned n_clusters, l2_n_ports);
    int unsigned w;
    w = $clog2(n_targets(n_clusters, l2_n_ports));
    return (w < 1) ? 1 : w;
  endfunction

  function logic [31:0] cluster_start(input int unsigned idx);
    return cluster_base + 32'(idx * cluster_stride);
  endfunction

  function logic [31:0] l2_start(input int unsigned idx, bytes_per_port);
    return l2_base + 32'(idx * bytes_per_port);
  endfunction

  // First byte above the last L2 port
  function logic [31:0] l2_end(input int unsigned n_ports, bytes_per_port);
    return l2_start(n_ports, bytes_per_port);
  endfunction

  function logic in_window(input logic [31:0] addr, base, size);
    return (addr >= base) && ((addr - base) < size);
  endfunction

endpackage

/* source/soc_bus_decode.sv */
// Address decoder that maps a captured request address onto a target index
`timescale 1ns/1ps

module soc_bus_decode #(
  parameter int unsigned N_CLUSTERS        = 2,
  parameter int unsigned L2_N_PORTS        = 2,
  parameter int unsigned L2_BYTES_PER_PORT = 32'h0001_0000
) (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n,
  input  logic [apb_pkg::addr_w-1:0]                            addr,
  input  logic                                                  addr_valid,
  output logic [soc_bus_pkg::tgt_idx_w(N_CLUSTERS, L2_N_PORTS)-1:0] tgt_idx,
  output logic                                                  unmapped
);

  import soc_bus_pkg::*;

  localparam int unsigned TIW = tgt_idx_w(N_CLUSTERS, L2_N_PORTS);

  logic [N_CLUSTERS-1:0] cl_hit;
  logic [L2_N_PORTS-1:0] l2_hit;
  logic [2:0]            ext_hit;

  // Rule matching, one flag per window
  always_comb begin
    for (int i = 0; i < N_CLUSTERS; i++) begin
      cl_hit[i] = in_window(addr, cluster_start(i), cluster_size);
    end
    for (int i = 0; i < L2_N_PORTS; i++) begin
      l2_hit[i] = in_window(addr, l2_start(i, L2_BYTES_PER_PORT),
                            32'(L2_BYTES_PER_PORT));
    end
    // Below the clusters, the 0x1A window, above the L2 ports
    ext_hit[0] = addr < cluster_base;
    ext_hit[1] = (addr >= ext_win_base) && (addr <= ext_win_end);
    ext_hit[2] = addr >= l2_end(L2_N_PORTS, L2_BYTES_PER_PORT);
  end

  // Later assignments win, so clusters take priority over L2 over external
  always_comb begin
    tgt_idx  = '0;
    unmapped = 1'b1;
    if (|ext_hit) begin
      tgt_idx  = TIW'(idx_ext(N_CLUSTERS, L2_N_PORTS));
      unmapped = 1'b0;
    end
    for (int i = L2_N_PORTS - 1; i >= 0; i--) begin
      if (l2_hit[i]) begin
        tgt_idx  = TIW'(idx_l2(N_CLUSTERS) + i);
        unmapped = 1'b0;
      end
    end
    for (int i = N_CLUSTERS - 1; i >= 0; i--) begin
      if (cl_hit[i]) begin
        tgt_idx  = TIW'(i);
        unmapped = 1'b0;
      end
    end
  end

  // The address map must stay free of overlaps for any legal parameter set
  a_rules_disjoint: assert property (
    @(posedge clk_i) disable iff (!arst_n)
    addr_valid |-> $onehot0({cl_hit, l2_hit, ext_hit})
  ) else $error("address 0x%08h matches more than one rule", addr);

endmodule

/* source/soc_bus_execute.sv */
// APB sequencer that captures the upstream request and drives the target side
`timescale 1ns/1ps

module soc_bus_execute #(
  parameter int unsigned N_CLUSTERS = 2,
  parameter int unsigned L2_N_PORTS = 2
) (
  input  logic                                                  clk_i,
  input  logic                                                  arst_n,
  // Upstream request
  input  logic                                                  s_psel,
  input  logic                                                  s_penable,
  input  logic                                                  s_pwrite,
  input  logic [apb_pkg::addr_w-1:0]                            s_paddr,
  input  logic [apb_pkg::data_w-1:0]                            s_pwdata,
  input  logic [apb_pkg::strb_w-1:0]                            s_pstrb,
  // Downstream request
  output logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0] m_psel,
  output logic                                                  m_penable,
  output logic                                                  m_pwrite,
  output logic [apb_pkg::addr_w-1:0]                            m_paddr,
  output logic [apb_pkg::data_w-1:0]                            m_pwdata,
  output logic [apb_pkg::strb_w-1:0]                            m_pstrb,
  // Decoder side
  output logic [apb_pkg::addr_w-1:0]                            req_addr,
  output logic                                                  addr_valid,
  input  logic [soc_bus_pkg::tgt_idx_w(N_CLUSTERS, L2_N_PORTS)-1:0] tgt_idx,
  input  logic                                                  unmapped,
  // Result side
  input  logic                                                  sel_ready,
  output logic                                                  complete,
  output logic                                                  err_local
);

  import apb_pkg::*;
  import soc_bus_pkg::*;

  localparam int unsigned N_T = n_targets(N_CLUSTERS, L2_N_PORTS);
  localparam int unsigned TIW = tgt_idx_w(N_CLUSTERS, L2_N_PORTS);

  apb_state_e          state;
  apb_state_e          state_nxt;
  logic                start;
  logic                sel_phase;
  logic                pwrite_q;
  logic [addr_w-1:0]   paddr_q;
  logic [data_w-1:0]   pwdata_q;
  logic [strb_w-1:0]   pstrb_q;

  // A new transfer only starts on a clean setup cycle
  assign start     = s_psel && !s_penable;
  assign sel_phase = (state == SETUP) || (state == ACCESS);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (start) state_nxt = SETUP;
      SETUP:   state_nxt = unmapped ? RESPOND : ACCESS;
      ACCESS:  if (sel_ready) state_nxt = RESPOND;
      RESPOND: state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Request payload, held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (state == IDLE && start) begin
      pwrite_q <= s_pwrite;
      paddr_q  <= s_paddr;
      pwdata_q <= s_pwdata;
      pstrb_q  <= s_pstrb;
    end
  end

  assign req_addr   = paddr_q;
  assign addr_valid = sel_phase;

  for (genvar i = 0; i < N_T; i++) begin : gen_psel
    assign m_psel[i] = sel_phase && !unmapped && (tgt_idx == TIW'(i));
  end

  assign m_penable = (state == ACCESS);
  assign m_pwrite  = pwrite_q;
  assign m_paddr   = paddr_q;
  assign m_pwdata  = pwdata_q;
  assign m_pstrb   = pstrb_q;

  // Unmapped addresses finish in SETUP without touching any target
  assign err_local = (state == SETUP) && unmapped;
  assign complete  = err_local || ((state == ACCESS) && sel_ready);

  a_psel_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n) $onehot0(m_psel)
  ) else $error("more than one target selected");

  a_penable_psel: assert property (
    @(posedge clk_i) disable iff (!arst_n) m_penable |-> (|m_psel)
  ) else $error("penable raised with no target selected");

endmodule

/* source/soc_bus_result.sv */
// Response path that picks the selected target's reply and returns it upstream
`timescale 1ns/1ps

module soc_bus_result #(
  parameter int unsigned N_CLUSTERS = 2,
  parameter int unsigned L2_N_PORTS = 2
) (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n,
  input  logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0]
               [apb_pkg::data_w-1:0]                             m_prdata,
  input  logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0] m_pready,
  input  logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0] m_pslverr,
  input  logic [soc_bus_pkg::tgt_idx_w(N_CLUSTERS, L2_N_PORTS)-1:0]  tgt_idx,
  input  logic                                                   complete,
  input  logic                                                   err_local,
  output logic                                                   sel_ready,
  output logic [apb_pkg::data_w-1:0]                             s_prdata,
  output logic                                                   s_pready,
  output logic                                                   s_pslverr
);

  import apb_pkg::*;
  import soc_bus_pkg::*;

  localparam int unsigned N_T = n_targets(N_CLUSTERS, L2_N_PORTS);
  localparam int unsigned TIW = tgt_idx_w(N_CLUSTERS, L2_N_PORTS);

  logic [data_w-1:0] sel_rdata;
  logic              sel_err;

  // Response mux; out of range indices select nothing
  always_comb begin
    sel_ready = 1'b0;
    sel_rdata = '0;
    sel_err   = 1'b0;
    for (int i = 0; i < N_T; i++) begin
      if (tgt_idx == TIW'(i)) begin
        sel_ready = m_pready[i];
        sel_rdata = m_prdata[i];
        sel_err   = m_pslverr[i];
      end
    end
  end

  // One cycle upstream ready per completed transfer
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      s_pready  <= 1'b0;
      s_pslverr <= 1'b0;
    end else begin
      s_pready  <= complete;
      s_pslverr <= complete && (err_local || sel_err);
    end
  end

  // Read data, zero for a locally answered error
  always_ff @(posedge clk_i) begin
    if (complete) begin
      s_prdata <= err_local ? '0 : sel_rdata;
    end
  end

  a_pready_pulse: assert property (
    @(posedge clk_i) disable iff (!arst_n) s_pready |=> !s_pready
  ) else $error("upstream pready held for two cycles");

endmodule

/* source/soc_bus.sv */
// SoC bus top level with one APB completer port and per-target APB requester ports
`timescale 1ns/1ps

module soc_bus #(
  parameter int unsigned N_CLUSTERS        = 2,
  parameter int unsigned L2_N_PORTS        = 2,
  parameter int unsigned L2_BYTES_PER_PORT = 32'h0001_0000
) (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n,
  // Host side
  input  logic                                                   s_psel,
  input  logic                                                   s_penable,
  input  logic                                                   s_pwrite,
  input  logic [apb_pkg::addr_w-1:0]                             s_paddr,
  input  logic [apb_pkg::data_w-1:0]                             s_pwdata,
  input  logic [apb_pkg::strb_w-1:0]                             s_pstrb,
  output logic [apb_pkg::data_w-1:0]                             s_prdata,
  output logic                                                   s_pready,
  output logic                                                   s_pslverr,
  // Target side, clusters then L2 ports then external
  output logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0] m_psel,
  output logic                                                   m_penable,
  output logic                                                   m_pwrite,
  output logic [apb_pkg::addr_w-1:0]                             m_paddr,
  output logic [apb_pkg::data_w-1:0]                             m_pwdata,
  output logic [apb_pkg::strb_w-1:0]                             m_pstrb,
  input  logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0]
               [apb_pkg::data_w-1:0]                             m_prdata,
  input  logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0] m_pready,
  input  logic [soc_bus_pkg::n_targets(N_CLUSTERS, L2_N_PORTS)-1:0] m_pslverr
);

  import apb_pkg::*;
  import soc_bus_pkg::*;

  localparam int unsigned TIW = tgt_idx_w(N_CLUSTERS, L2_N_PORTS);

  logic [addr_w-1:0] req_addr;
  logic              addr_valid;
  logic [TIW-1:0]    tgt_idx;
  logic              unmapped;
  logic              sel_ready;
  logic              complete;
  logic              err_local;

  soc_bus_decode #(
    .N_CLUSTERS        (N_CLUSTERS),
    .L2_N_PORTS        (L2_N_PORTS),
    .L2_BYTES_PER_PORT (L2_BYTES_PER_PORT)
  ) u_decode (
    .clk_i      (clk_i),
    .arst_n     (arst_n),
    .addr       (req_addr),
    .addr_valid (addr_valid),
    .tgt_idx    (tgt_idx),
    .unmapped   (unmapped)
  );

  soc_bus_execute #(
    .N_CLUSTERS (N_CLUSTERS),
    .L2_N_PORTS (L2_N_PORTS)
  ) u_execute (
    .clk_i      (clk_i),
    .arst_n     (arst_n),
    .s_psel     (s_psel),
    .s_penable  (s_penable),
    .s_pwrite   (s_pwrite),
    .s_paddr    (s_paddr),
    .s_pwdata   (s_pwdata),
    .s_pstrb    (s_pstrb),
    .m_psel     (m_psel),
    .m_penable  (m_penable),
    .m_pwrite   (m_pwrite),
    .m_paddr    (m_paddr),
    .m_pwdata   (m_pwdata),
    .m_pstrb    (m_pstrb),
    .req_addr   (req_addr),
    .addr_valid (addr_valid),
    .tgt_idx    (tgt_idx),
    .unmapped   (unmapped),
    .sel_ready  (sel_ready),
    .complete   (complete),
    .err_local  (err_local)
  );

  soc_bus_result #(
    .N_CLUSTERS (N_CLUSTERS),
    .L2_N_PORTS (L2_N_PORTS)
  ) u_result (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .m_prdata  (m_prdata),
    .m_pready  (m_pready),
    .m_pslverr (m_pslverr),
    .tgt_idx   (tgt_idx),
    .complete  (complete),
    .err_local (err_local),
    .sel_ready (sel_ready),
    .s_prdata  (s_prdata),
    .s_pready  (s_pready),
    .s_pslverr (s_pslverr)
  );

endmodule

/* sim/tb_apb_target.sv */
// Behavioral APB target with a 16 word memory, byte strobes and random wait states
`timescale 1ns/1ps

module tb_apb_target #(
  parameter int unsigned ID   = 0,
  parameter logic [15:0] SEED = 16'h0001
) (
  input  logic        clk_i,
  input  logic        arst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  input  logic [3:0]  pstrb,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic [31:0] mem [16];
  logic [15:0] lfsr;
  logic [15:0] lfsr_1;
  logic [15:0] lfsr_2;
  logic [1:0]  wait_n;
  logic [1:0]  wait_cnt;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  assign lfsr_1  = lfsr_next(lfsr);
  assign lfsr_2  = lfsr_next(lfsr_1);
  assign pready  = psel && penable && (wait_cnt == wait_n);
  assign prdata  = mem[paddr[5:2]];
  assign pslverr = 1'b0;

  always @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      lfsr     <= SEED;
      wait_n   <= '0;
      wait_cnt <= '0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= {8'h5A, 8'(ID), 8'(i), 8'(~i)};
      end
    end else if (psel && !penable) begin
      // One LFSR bit per wait count bit
      wait_n   <= {lfsr[0], lfsr_1[0]};
      wait_cnt <= '0;
      lfsr     <= lfsr_2;
    end else if (psel && penable && pready) begin
      if (pwrite) begin
        for (int b = 0; b < 4; b++) begin
          if (pstrb[b]) begin
            mem[paddr[5:2]][8*b +: 8] <= pwdata[8*b +: 8];
          end
        end
      end
    end else if (psel && penable) begin
      wait_cnt <= wait_cnt + 2'd1;
    end
  end

endmodule

/* sim/tb_soc_bus.sv */
// Testbench top with clock, reset, APB host stimulus, reference address map and checks
`timescale 1ns/1ps

module tb_soc_bus;

  import apb_pkg::*;

  localparam int unsigned N_CLUSTERS        = 2;
  localparam int unsigned L2_N_PORTS        = 2;
  localparam int unsigned L2_BYTES_PER_PORT = 32'h0001_0000;
  localparam int unsigned N_T               = N_CLUSTERS + L2_N_PORTS + 1;
  localparam logic [31:0] L2_TOP            = 32'h1C00_0000 + L2_N_PORTS * L2_BYTES_PER_PORT;

  // All three external rules, then the holes of the map
  localparam logic [31:0] EXT_ADDRS [6] = '{32'h0000_0000, 32'h0FFF_FFFC, 32'h1A00_0000,
                                            32'h1AFF_FFFC, L2_TOP, 32'hFFFF_FFFC};
  localparam logic [31:0] HOLE_ADDRS [6] = '{32'h1030_0000, 32'h103F_FFFC, 32'h1070_0000,
                                             32'h19FF_FFFC, 32'h1B00_0000, 32'h1BFF_FFFC};
  localparam logic [31:0] STRB_ADDRS [3] = '{32'h1000_0020, 32'h1C00_0020, 32'h0000_0020};

  logic                       clk;
  logic                       arst_n;
  logic                       s_psel;
  logic                       s_penable;
  logic                       s_pwrite;
  logic [addr_w-1:0]          s_paddr;
  logic [data_w-1:0]          s_pwdata;
  logic [strb_w-1:0]          s_pstrb;
  logic [data_w-1:0]          s_prdata;
  logic                       s_pready;
  logic                       s_pslverr;
  logic [N_T-1:0]             m_psel;
  logic                       m_penable;
  logic                       m_pwrite;
  logic [addr_w-1:0]          m_paddr;
  logic [data_w-1:0]          m_pwdata;
  logic [strb_w-1:0]          m_pstrb;
  logic [N_T-1:0][data_w-1:0] m_prdata;
  logic [N_T-1:0]             m_pready;
  logic [N_T-1:0]             m_pslverr;

  logic [31:0]    lfsr_q = 32'd73;
  logic [31:0]    shadow [N_T][16];
  string          test_name = "reset";
  int             cyc = 0;
  int             n_issued = 0;
  int             n_done = 0;
  int             setup_cyc;
  int             ready_cyc;
  int             exp_idx;
  logic [N_T-1:0] psel_seen;

  soc_bus #(
    .N_CLUSTERS        (N_CLUSTERS),
    .L2_N_PORTS        (L2_N_PORTS),
    .L2_BYTES_PER_PORT (L2_BYTES_PER_PORT)
  ) dut (
    .clk_i     (clk),
    .arst_n    (arst_n),
    .s_psel    (s_psel),
    .s_penable (s_penable),
    .s_pwrite  (s_pwrite),
    .s_paddr   (s_paddr),
    .s_pwdata  (s_pwdata),
    .s_pstrb   (s_pstrb),
    .s_prdata  (s_prdata),
    .s_pready  (s_pready),
    .s_pslverr (s_pslverr),
    .m_psel    (m_psel),
    .m_penable (m_penable),
    .m_pwrite  (m_pwrite),
    .m_paddr   (m_paddr),
    .m_pwdata  (m_pwdata),
    .m_pstrb   (m_pstrb),
    .m_prdata  (m_prdata),
    .m_pready  (m_pready),
    .m_pslverr (m_pslverr)
  );

  for (genvar t = 0; t < N_T; t++) begin : gen_tgt
    tb_apb_target #(
      .ID   (t),
      .SEED (16'(16'h01D1 + t * 16'h025B))
    ) u_tgt (
      .clk_i   (clk),
      .arst_n  (arst_n),
      .psel    (m_psel[t]),
      .penable (m_penable),
      .pwrite  (m_pwrite),
      .paddr   (m_paddr),
      .pwdata  (m_pwdata),
      .pstrb   (m_pstrb),
      .prdata  (m_prdata[t]),
      .pready  (m_pready[t]),
      .pslverr (m_pslverr[t])
    );
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      stop_run($sformatf("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h",
                         test_name, what, exp, act));
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // Power-up contents of each target word
  function automatic logic [31:0] fill_word(input int tgt, input int word);
    return {8'h5A, 8'(tgt), 8'(word), 8'(~word)};
  endfunction

  // Expected target index, -1 when nothing is mapped there
  function automatic int exp_target(input logic [31:0] addr);
    longint a;
    longint lo;
    a = longint'(addr);
    for (int i = 0; i < N_CLUSTERS; i++) begin
      lo = 64'h1000_0000 + i * 64'h40_0000;
      if (a >= lo && a < lo + 64'h30_0000) return i;
    end
    for (int i = 0; i < L2_N_PORTS; i++) begin
      lo = 64'h1C00_0000 + i * L2_BYTES_PER_PORT;
      if (a >= lo && a < lo + L2_BYTES_PER_PORT) return N_CLUSTERS + i;
    end
    if (a < 64'h1000_0000 || (a >= 64'h1A00_0000 && a <= 64'h1AFF_FFFF) || a >= L2_TOP) begin
      return N_CLUSTERS + L2_N_PORTS;
    end
    return -1;
  endfunction

  function automatic logic [N_T-1:0] psel_of(input int idx);
    return (idx < 0) ? '0 : (N_T'(1) << idx);
  endfunction

  // Spread random addresses over clusters, L2 ports, external rules and one hole
  function automatic logic [31:0] rand_addr();
    logic [2:0] sel;
    logic [1:0] rule;
    sel = 3'(rand_bits(3));
    if (sel < N_CLUSTERS) return 32'h1000_0000 + 32'(sel) * 32'h40_0000 + (rand_bits(18) << 2);
    if (sel < N_CLUSTERS + L2_N_PORTS) begin
      return 32'h1C00_0000 + 32'(sel - N_CLUSTERS) * L2_BYTES_PER_PORT + (rand_bits(14) << 2);
    end
    if (sel == 3'd7) return 32'h1B00_0000 + (rand_bits(22) << 2);
    rule = 2'(rand_bits(2));
    if (rule == 2'd0) return rand_bits(26) << 2;
    if (rule == 2'd1) return 32'h1A00_0000 + (rand_bits(22) << 2);
    return 32'hF000_0000 + (rand_bits(26) << 2);
  endfunction

  task automatic apb_xfer(input logic wr, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb);
    @(posedge clk);
    #1;
    s_psel    = 1'b1;
    s_penable = 1'b0;
    s_pwrite  = wr;
    s_paddr   = addr;
    s_pwdata  = data;
    s_pstrb   = wr ? strb : 4'h0;
    n_issued++;
    @(posedge clk);
    #1;
    s_penable = 1'b1;
    do begin
      @(negedge clk);
    end while (!s_pready);
    @(posedge clk);
    #1;
    s_psel    = 1'b0;
    s_penable = 1'b0;
  endtask

  task automatic write_read(input logic [31:0] addr, input logic [31:0] data);
    apb_xfer(1'b1, addr, data, 4'hF);
    apb_xfer(1'b0, addr, '0, 4'hF);
  endtask

  // Compares one upstream completion with the address map and the shadow memory
  task automatic check_response();
    int w;
    n_done++;
    check_value("psel during transfer", 32'(psel_of(exp_idx)), 32'(psel_seen));
    if (exp_idx < 0) begin
      check_value("unmapped latency", 2, cyc - setup_cyc);
      check_value("unmapped pslverr", 1, 32'(s_pslverr));
      check_value("unmapped prdata", 0, s_prdata);
    end else begin
      assert (ready_cyc >= 0) else begin
        stop_run($sformatf("Target %0d finished in %s without raising pready",
                           exp_idx, test_name));
      end
      w = ready_cyc - setup_cyc - 2;
      check_value("mapped latency", 3 + w, cyc - setup_cyc);
      check_value("pslverr", 0, 32'(s_pslverr));
      if (s_pwrite) begin
        for (int b = 0; b < 4; b++) begin
          if (s_pstrb[b]) shadow[exp_idx][s_paddr[5:2]][8*b +: 8] = s_pwdata[8*b +: 8];
        end
      end else begin
        check_value("read data", shadow[exp_idx][s_paddr[5:2]], s_prdata);
      end
    end
  endtask

  // Sampled on the falling edge, half a cycle away from every driver
  always @(negedge clk) begin
    if (arst_n) begin
      if (s_psel && !s_penable) begin
        setup_cyc = cyc;
        ready_cyc = -1;
        psel_seen = '0;
        exp_idx   = exp_target(s_paddr);
      end
      psel_seen = psel_seen | m_psel;
      // Downstream setup one cycle after the upstream one, carrying the host request
      if ((m_psel != '0) && !m_penable) begin
        check_value("setup psel", 32'(psel_of(exp_idx)), 32'(m_psel));
        check_value("setup cycle", 1, cyc - setup_cyc);
        check_value("paddr", s_paddr, m_paddr);
        check_value("pwrite", 32'(s_pwrite), 32'(m_pwrite));
        check_value("pwdata", s_pwdata, m_pwdata);
        check_value("pstrb", 32'(s_pstrb), 32'(m_pstrb));
      end
      if (m_penable && ((m_psel & m_pready) != '0) && (ready_cyc < 0)) ready_cyc = cyc;
      if (s_pready) check_response();
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > 60 * n_issued + 100) begin
      stop_run($sformatf("Timeout after %0d cycles with %0d transfers issued", cyc, n_issued));
    end
  end

  initial begin
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    s_psel    = 1'b0;
    s_penable = 1'b0;
    s_pwrite  = 1'b0;
    s_paddr   = '0;
    s_pwdata  = '0;
    s_pstrb   = '0;
    arst_n    = 1'b0;
    for (int t = 0; t < N_T; t++) begin
      for (int k = 0; k < 16; k++) begin
        shadow[t][k] = fill_word(t, k);
      end
    end
    @(posedge clk);
    @(negedge clk);
    check_value("outputs in reset", 0, 32'({m_psel, m_penable, s_pready, s_pslverr}));
    @(posedge clk);
    #1;
    arst_n = 1'b1;

    test_name = "cluster";
    for (int i = 0; i < N_CLUSTERS; i++) begin
      write_read(32'h1000_0000 + 32'(i) * 32'h40_0000, rand_bits(32));
      write_read(32'h102F_FFFC + 32'(i) * 32'h40_0000, rand_bits(32));
    end

    // Last word of each port sits next to the first word of the following one
    test_name = "l2";
    for (int i = 0; i < L2_N_PORTS; i++) begin
      addr = 32'h1C00_0000 + 32'(i) * L2_BYTES_PER_PORT;
      apb_xfer(1'b1, addr, rand_bits(32), 4'hF);
      apb_xfer(1'b1, addr + L2_BYTES_PER_PORT - 4, rand_bits(32), 4'hF);
      apb_xfer(1'b0, addr, '0, 4'hF);
      apb_xfer(1'b0, addr + L2_BYTES_PER_PORT - 4, '0, 4'hF);
    end

    test_name = "external";
    for (int k = 0; k < 6; k++) write_read(EXT_ADDRS[k], rand_bits(32));

    test_name = "unmapped";
    for (int k = 0; k < 6; k++) write_read(HOLE_ADDRS[k], rand_bits(32));

    test_name = "strobe";
    for (int k = 0; k < 3; k++) begin
      apb_xfer(1'b1, STRB_ADDRS[k], 32'h1122_3344, 4'hF);
      apb_xfer(1'b1, STRB_ADDRS[k], 32'hAABB_CCDD, 4'b0101);
      apb_xfer(1'b0, STRB_ADDRS[k], '0, 4'hF);
      apb_xfer(1'b1, STRB_ADDRS[k], 32'h99EE_FF00, 4'b1000);
      apb_xfer(1'b0, STRB_ADDRS[k], '0, 4'hF);
    end

    test_name = "random";
    repeat (200) begin
      wr   = 1'(rand_bits(1));
      addr = rand_addr();
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      apb_xfer(wr, addr, data, strb);
    end

    test_name = "end";
    repeat (2) @(posedge clk);
    if (n_done == n_issued) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_run($sformatf("%0d transfers issued but only %0d completed", n_issued, n_done));
    end
  end

endmodule

/* sim.f */
source/apb_pkg.sv
source/soc_bus_pkg.sv
source/soc_bus_decode.sv
source/soc_bus_execute.sv
source/soc_bus_result.sv
source/soc_bus.sv
sim/tb_apb_target.sv
sim/tb_soc_bus.sv

/* Makefile */
# Verilator build and run of the SoC bus testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
